// File: bp_pkg.sv
package bp_pkg;

    typedef logic [31:0] rv32i_word;

    typedef enum logic {
        nottaken = 1'b0,
        taken    = 1'b1
    } predictmux_t;

    // two-bit saturating counter, also used as the tournament chooser.
    typedef enum logic [1:0] {
        strong_n_take = 2'b00,
        n_take        = 2'b01,
        take          = 2'b10,
        strong_take   = 2'b11
    } counter_t;

    localparam int addr_start         = 2;  // pcs are word aligned.
    localparam int local_index_bits   = 7;
    localparam int history_bits       = 8;
    localparam int gshare_index_bits  = 8;
    localparam int chooser_index_bits = 8;
    localparam int btb_index_bits     = 6;
    localparam int btb_tag_bits       = 32 - addr_start - btb_index_bits;

    localparam int local_sets   = 2**local_index_bits;
    localparam int gshare_sets  = 2**gshare_index_bits;
    localparam int chooser_sets = 2**chooser_index_bits;
    localparam int btb_sets     = 2**btb_index_bits;

    // upper half of the counter predicts taken.
    function automatic predictmux_t counter_dir(counter_t state);
        if (state == take || state == strong_take) begin
            return taken;
        end
        return nottaken;
    endfunction

    // on a miss the counter crosses toward the other side,
    // otherwise it saturates on its own side.
    function automatic counter_t counter_next(counter_t state, logic failed);
        counter_t next;
        case (state)
            strong_n_take: next = failed ? n_take : strong_n_take;
            n_take:        next = failed ? take   : strong_n_take;
            take:          next = failed ? n_take : strong_take;
            strong_take:   next = failed ? take   : strong_take;
            default:       next = n_take;
        endcase
        return next;
    endfunction

endpackage

// File: local_prediction_table.sv
`timescale 1ns/1ps

module local_prediction_table
    import bp_pkg::*;
(
    input  logic        clk,
    input  logic        rst,

    input  logic        update_en,
    input  rv32i_word   curr_pc,
    input  rv32i_word   resolved_pc,
    input  logic        prediction_failed,

    output predictmux_t predicted_direction
);

    counter_t counters [local_sets];

    logic [local_index_bits-1:0] curr_index;
    logic [local_index_bits-1:0] resolved_index;

    counter_t resolved_state;
    counter_t next_state;

    assign curr_index     = curr_pc[addr_start +: local_index_bits];
    assign resolved_index = resolved_pc[addr_start +: local_index_bits];

    // lookup on the fetch pc.
    assign predicted_direction = counter_dir(counters[curr_index]);

    always_comb begin
        resolved_state = counters[resolved_index];
        next_state     = counter_next(resolved_state, prediction_failed);
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            for (int i = 0; i < local_sets; i++) begin
                counters[i] <= n_take;  // weakly not taken.
            end
        end else if (update_en) begin
            counters[resolved_index] <= next_state;
        end
    end

endmodule

// File: gshare_prediction_table.sv
`timescale 1ns/1ps

module gshare_prediction_table
    import bp_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst,

    input  logic                    update_en,
    input  rv32i_word               curr_pc,
    input  rv32i_word               resolved_pc,
    input  logic [history_bits-1:0] resolved_history,
    input  predictmux_t             resolved_taken,
    input  logic                    prediction_failed,

    output predictmux_t             predicted_direction,
    output logic [history_bits-1:0] history
);

    counter_t counters [gshare_sets];

    logic [gshare_index_bits-1:0] curr_index;
    logic [gshare_index_bits-1:0] resolved_index;

    counter_t resolved_state;
    counter_t next_state;

    // lookup hashes with the live history, update with the snapshot
    // the branch carried down the pipe.
    assign curr_index     = curr_pc[addr_start +: gshare_index_bits] ^ history;
    assign resolved_index = resolved_pc[addr_start +: gshare_index_bits] ^ resolved_history;

    assign predicted_direction = counter_dir(counters[curr_index]);

    always_comb begin
        resolved_state = counters[resolved_index];
        next_state     = counter_next(resolved_state, prediction_failed);
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            for (int i = 0; i < gshare_sets; i++) begin
                counters[i] <= n_take;
            end
        end else if (update_en) begin
            counters[resolved_index] <= next_state;
        end
    end

    // global history, non speculative.
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            history <= '0;
        end else if (update_en) begin
            history <= {history[history_bits-2:0], (resolved_taken == taken)};  // newest in bit 0.
        end
    end

endmodule

// File: branch_target_buffer.sv
`timescale 1ns/1ps

module branch_target_buffer
    import bp_pkg::*;
(
    input  logic        clk,
    input  logic        rst,

    input  logic        update_en,
    input  rv32i_word   curr_pc,
    input  rv32i_word   resolved_pc,
    input  predictmux_t resolved_taken,
    input  rv32i_word   resolved_target,

    output logic        hit,
    output rv32i_word   target
);

    localparam int tag_start = addr_start + btb_index_bits;

    logic                    valid   [btb_sets];
    logic [btb_tag_bits-1:0] tags    [btb_sets];
    rv32i_word               targets [btb_sets];

    logic [btb_index_bits-1:0] curr_index;
    logic [btb_tag_bits-1:0]   curr_tag;
    logic [btb_index_bits-1:0] resolved_index;
    logic [btb_tag_bits-1:0]   resolved_tag;

    logic write_en;

    // pc splits as tag | index | byte offset.
    assign curr_index     = curr_pc[addr_start +: btb_index_bits];
    assign curr_tag       = curr_pc[tag_start +: btb_tag_bits];
    assign resolved_index = resolved_pc[addr_start +: btb_index_bits];
    assign resolved_tag   = resolved_pc[tag_start +: btb_tag_bits];

    // only taken branches allocate.
    assign write_en = update_en && (resolved_taken == taken);

    assign hit    = valid[curr_index] && (tags[curr_index] == curr_tag);
    assign target = targets[curr_index];

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            for (int i = 0; i < btb_sets; i++) begin
                valid[i] <= 1'b0;
            end
        end else if (write_en) begin
            valid[resolved_index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (write_en) begin
            tags[resolved_index]    <= resolved_tag;
            targets[resolved_index] <= resolved_target;  // latest target wins.
        end
    end

endmodule

// File: tournament_selector.sv
`timescale 1ns/1ps

module tournament_selector
    import bp_pkg::*;
(
    input  logic        clk,
    input  logic        rst,

    input  logic        update_en,
    input  rv32i_word   curr_pc,
    input  rv32i_word   resolved_pc,

    input  predictmux_t local_dir,
    input  predictmux_t global_dir,
    input  logic        btb_hit,
    input  rv32i_word   btb_target,

    input  predictmux_t resolved_local_dir,
    input  predictmux_t resolved_global_dir,
    input  predictmux_t resolved_taken,

    output logic        predict_taken,
    output rv32i_word   predicted_pc,
    output logic        local_failed,
    output logic        global_failed
);

    // lower half prefers local, upper half prefers global.
    counter_t choosers [chooser_sets];

    logic [chooser_index_bits-1:0] curr_index;
    logic [chooser_index_bits-1:0] resolved_index;

    counter_t    curr_choice;
    logic        use_global;
    predictmux_t final_dir;

    counter_t resolved_choice;
    counter_t next_choice;

    assign curr_index     = curr_pc[addr_start +: chooser_index_bits];
    assign resolved_index = resolved_pc[addr_start +: chooser_index_bits];

    always_comb begin
        curr_choice = choosers[curr_index];
        use_global  = (curr_choice == take) || (curr_choice == strong_take);
        final_dir   = use_global ? global_dir : local_dir;
    end

    // a taken guess without a target is useless, fall through instead.
    assign predict_taken = (final_dir == taken) && btb_hit;
    assign predicted_pc  = predict_taken ? btb_target : curr_pc + 32'd4;

    assign local_failed  = (resolved_local_dir != resolved_taken);
    assign global_failed = (resolved_global_dir != resolved_taken);

    always_comb begin
        resolved_choice = choosers[resolved_index];
        next_choice     = resolved_choice;
        if (local_failed && !global_failed) begin  // global was right.
            case (resolved_choice)
                strong_n_take: next_choice = n_take;
                n_take:        next_choice = take;
                default:       next_choice = strong_take;
            endcase
        end else if (global_failed && !local_failed) begin  // local was right.
            case (resolved_choice)
                strong_take: next_choice = take;
                take:        next_choice = n_take;
                default:     next_choice = strong_n_take;
            endcase
        end
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            for (int i = 0; i < chooser_sets; i++) begin
                choosers[i] <= n_take;
            end
        end else if (update_en) begin
            choosers[resolved_index] <= next_choice;
        end
    end

endmodule

// File: branch_predictor.sv
`timescale 1ns/1ps

module branch_predictor
    import bp_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst,

    // fetch side.
    input  rv32i_word               fetch_pc,
    output logic                    predict_taken,
    output rv32i_word               predicted_pc,
    output predictmux_t             local_dir,
    output predictmux_t             global_dir,
    output logic [history_bits-1:0] fetch_history,

    // resolve side, one strobe per conditional branch.
    input  logic                    resolve_en,
    input  rv32i_word               resolved_pc,
    input  predictmux_t             resolved_taken,
    input  rv32i_word               resolved_target,
    input  predictmux_t             resolved_local_dir,
    input  predictmux_t             resolved_global_dir,
    input  logic [history_bits-1:0] resolved_history
);

    logic      btb_hit;
    rv32i_word btb_target;
    logic      local_failed;
    logic      global_failed;

    local_prediction_table local_table (
        .clk                 (clk),
        .rst                 (rst),
        .update_en           (resolve_en),
        .curr_pc             (fetch_pc),
        .resolved_pc         (resolved_pc),
        .prediction_failed   (local_failed),
        .predicted_direction (local_dir)
    );

    gshare_prediction_table gshare_table (
        .clk                 (clk),
        .rst                 (rst),
        .update_en           (resolve_en),
        .curr_pc             (fetch_pc),
        .resolved_pc         (resolved_pc),
        .resolved_history    (resolved_history),
        .resolved_taken      (resolved_taken),
        .prediction_failed   (global_failed),
        .predicted_direction (global_dir),
        .history             (fetch_history)
    );

    branch_target_buffer btb (
        .clk             (clk),
        .rst             (rst),
        .update_en       (resolve_en),
        .curr_pc         (fetch_pc),
        .resolved_pc     (resolved_pc),
        .resolved_taken  (resolved_taken),
        .resolved_target (resolved_target),
        .hit             (btb_hit),
        .target          (btb_target)
    );

    // picks between the tables and flags which one missed.
    tournament_selector selector (
        .clk                 (clk),
        .rst                 (rst),
        .update_en           (resolve_en),
        .curr_pc             (fetch_pc),
        .resolved_pc         (resolved_pc),
        .local_dir           (local_dir),
        .global_dir          (global_dir),
        .btb_hit             (btb_hit),
        .btb_target          (btb_target),
        .resolved_local_dir  (resolved_local_dir),
        .resolved_global_dir (resolved_global_dir),
        .resolved_taken      (resolved_taken),
        .predict_taken       (predict_taken),
        .predicted_pc        (predicted_pc),
        .local_failed        (local_failed),
        .global_failed       (global_failed)
    );

endmodule

// File: tb_branch_predictor.sv
`timescale 1ns/1ps

module tb_branch_predictor
    import bp_pkg::*;
();

    localparam int clk_period      = 100;
    localparam int reset_cycles    = 10;
    localparam int random_iters    = 200;
    localparam int directed_cycles = 150;
    // a resolve with its lookup takes three cycles, an extra lookup one more.
    localparam int max_cycles = reset_cycles + directed_cycles + 4 * random_iters + 100;
    localparam int tag_shift  = addr_start + btb_index_bits;

    logic                    clk;
    logic                    rst;
    rv32i_word               fetch_pc;
    logic                    predict_taken;
    rv32i_word               predicted_pc;
    predictmux_t             local_dir;
    predictmux_t             global_dir;
    logic [history_bits-1:0] fetch_history;
    logic                    resolve_en;
    rv32i_word               resolved_pc;
    predictmux_t             resolved_taken;
    rv32i_word               resolved_target;
    predictmux_t             resolved_local_dir;
    predictmux_t             resolved_global_dir;
    logic [history_bits-1:0] resolved_history;

    int checks;
    int errors;
    int mark_checks;
    int mark_errors;
    int seed_val;

    // reference model.
    counter_t                m_local   [local_sets];
    counter_t                m_gshare  [gshare_sets];
    counter_t                m_chooser [chooser_sets];
    logic                    m_valid   [btb_sets];
    rv32i_word               m_btb_pc  [btb_sets];
    rv32i_word               m_btb_tgt [btb_sets];
    logic [history_bits-1:0] m_hist;

    predictmux_t exp_local;
    predictmux_t exp_global;
    logic        exp_taken;
    rv32i_word   exp_pc;

    branch_predictor DUT (.*);

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin
        #(max_cycles * clk_period);
        $display("watchdog: the tests did not finish within %0d cycles", max_cycles);
        $display("TB FAILED");
        $finish;
    end

    task automatic check_dir(string what, predictmux_t got, predictmux_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t: %s is %s, expected %s", $time, what, got.name(), exp.name());
        end
    endtask

    task automatic check_word(string what, rv32i_word got, rv32i_word exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(string what, logic got, logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_hist(string what, logic [history_bits-1:0] got,
                              logic [history_bits-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic report_test(string name);
        $display("%-18s %0d checks, %0d errors", name, checks - mark_checks,
                 errors - mark_errors);
        mark_checks = checks;
        mark_errors = errors;
    endtask

    // values 0..3; a miss moves one step across, a hit saturates.
    function automatic counter_t step_counter(counter_t state, logic wrong);
        int v;
        v = int'(state);
        if (wrong) begin
            v = (v < 2) ? v + 1 : v - 1;
        end else begin
            v = (v < 2) ? 0 : 3;
        end
        return counter_t'(v);
    endfunction

    task automatic model_reset();
        for (int i = 0; i < local_sets; i++) m_local[i] = n_take;
        for (int i = 0; i < gshare_sets; i++) m_gshare[i] = n_take;
        for (int i = 0; i < chooser_sets; i++) m_chooser[i] = n_take;
        for (int i = 0; i < btb_sets; i++) m_valid[i] = 1'b0;
        m_hist = '0;
    endtask

    task automatic model_lookup(rv32i_word pc);
        int          bi;
        logic        hit;
        predictmux_t pick;
        bi         = int'((pc >> addr_start) % btb_sets);
        exp_local  = (m_local[(pc >> addr_start) % local_sets] >= take) ? taken : nottaken;
        exp_global = (m_gshare[((pc >> addr_start) ^ m_hist) % gshare_sets] >= take)
                     ? taken : nottaken;
        pick       = (m_chooser[(pc >> addr_start) % chooser_sets] >= take)
                     ? exp_global : exp_local;
        hit        = m_valid[bi] && ((m_btb_pc[bi] >> tag_shift) == (pc >> tag_shift));
        exp_taken  = (pick == taken) && hit;
        exp_pc     = exp_taken ? m_btb_tgt[bi] : pc + 32'd4;
    endtask

    task automatic model_update(rv32i_word pc, predictmux_t outcome, rv32i_word target,
                                predictmux_t ldir, predictmux_t gdir,
                                logic [history_bits-1:0] hist);
        int   li;
        int   gi;
        int   ci;
        int   bi;
        logic lw;
        logic gw;
        li = int'((pc >> addr_start) % local_sets);
        gi = int'(((pc >> addr_start) ^ hist) % gshare_sets);
        ci = int'((pc >> addr_start) % chooser_sets);
        bi = int'((pc >> addr_start) % btb_sets);
        lw = (ldir != outcome);
        gw = (gdir != outcome);
        m_local[li]  = step_counter(m_local[li], lw);
        m_gshare[gi] = step_counter(m_gshare[gi], gw);
        if (lw && !gw && m_chooser[ci] != strong_take) begin
            m_chooser[ci] = counter_t'(int'(m_chooser[ci]) + 1);  // toward global.
        end else if (gw && !lw && m_chooser[ci] != strong_n_take) begin
            m_chooser[ci] = counter_t'(int'(m_chooser[ci]) - 1);
        end
        if (outcome == taken) begin
            m_valid[bi]   = 1'b1;
            m_btb_pc[bi]  = pc;
            m_btb_tgt[bi] = target;
        end
        m_hist = {m_hist[history_bits-2:0], outcome == taken};
    endtask

    task automatic lookup(rv32i_word pc);
        string tag;
        tag = $sformatf("pc %h", pc);
        @(negedge clk);
        fetch_pc = pc;
        #(clk_period / 4);
        model_lookup(pc);
        check_dir({tag, " local_dir"}, local_dir, exp_local);
        check_dir({tag, " global_dir"}, global_dir, exp_global);
        check_bit({tag, " predict_taken"}, predict_taken, exp_taken);
        check_word({tag, " predicted_pc"}, predicted_pc, exp_pc);
        check_hist({tag, " fetch_history"}, fetch_history, m_hist);
    endtask

    task automatic issue_resolve(rv32i_word pc, predictmux_t outcome, rv32i_word target,
                                 predictmux_t ldir, predictmux_t gdir,
                                 logic [history_bits-1:0] hist);
        @(negedge clk);
        resolve_en          = 1'b1;
        resolved_pc         = pc;
        resolved_taken      = outcome;
        resolved_target     = target;
        resolved_local_dir  = ldir;
        resolved_global_dir = gdir;
        resolved_history    = hist;
        @(posedge clk);
        model_update(pc, outcome, target, ldir, gdir, hist);
        @(negedge clk);
        resolve_en = 1'b0;
    endtask

    // metadata comes back from the lookup, as the fetch pipe would carry it.
    task automatic resolve_branch(rv32i_word pc, predictmux_t outcome, rv32i_word target);
        lookup(pc);
        issue_resolve(pc, outcome, target, local_dir, global_dir, fetch_history);
    endtask

    task automatic test_reset_state();
        rv32i_word pcs [4];
        pcs = '{32'h0000_0000, 32'h0000_0100, 32'h1234_5678, 32'hffff_fffc};
        foreach (pcs[i]) begin
            lookup(pcs[i]);
            check_dir("reset local_dir", local_dir, nottaken);
            check_dir("reset global_dir", global_dir, nottaken);
            check_bit("reset predict_taken", predict_taken, 1'b0);
            check_word("reset predicted_pc", predicted_pc, pcs[i] + 32'd4);
        end
        report_test("reset_state");
    endtask

    task automatic test_btb_fill();
        rv32i_word br;
        rv32i_word tgt;
        br  = 32'h0000_1000;
        tgt = 32'h0000_2000;
        resolve_branch(br, taken, tgt);
        lookup(br);
        check_bit("filled predict_taken", predict_taken, 1'b1);
        check_word("filled predicted_pc", predicted_pc, tgt);
        lookup(br + 32'h0001_0000);  // same indexes, other tag.
        check_dir("alias local_dir", local_dir, taken);
        check_bit("alias predict_taken", predict_taken, 1'b0);
        check_word("alias predicted_pc", predicted_pc, br + 32'h0001_0004);
        resolve_branch(br + 32'h0000_0100, nottaken, 32'h0000_3000);  // same btb set.
        lookup(br);
        check_bit("kept predict_taken", predict_taken, 1'b1);
        check_word("kept predicted_pc", predicted_pc, tgt);
        report_test("btb_fill");
    endtask

    task automatic test_local_hysteresis();
        rv32i_word pc;
        rv32i_word tgt;
        pc  = 32'h0000_4008;
        tgt = 32'h0000_4100;
        resolve_branch(pc, taken, tgt);
        resolve_branch(pc, taken, tgt);
        lookup(pc);
        check_dir("strong_take local_dir", local_dir, taken);
        resolve_branch(pc, nottaken, tgt);
        lookup(pc);
        check_dir("take local_dir", local_dir, taken);
        resolve_branch(pc, nottaken, tgt);
        lookup(pc);
        check_dir("n_take local_dir", local_dir, nottaken);
        resolve_branch(pc, nottaken, tgt);
        resolve_branch(pc, taken, tgt);  // one miss from strong_n_take.
        lookup(pc);
        check_dir("recovered local_dir", local_dir, nottaken);
        report_test("local_hysteresis");
    endtask

    task automatic test_global_history();
        logic [history_bits-1:0] pattern;
        logic [history_bits-1:0] after;
        rv32i_word               g_pc;
        rv32i_word               g2_pc;
        int                      i;
        pattern = 8'hb2;
        for (i = history_bits - 1; i >= 0; i--) begin
            resolve_branch(32'h0000_5000 + 4 * i, pattern[i] ? taken : nottaken,
                           32'h0000_6000 + 4 * i);
        end
        lookup(32'h0000_5000);
        check_hist("pattern history", fetch_history, pattern);
        g_pc = 32'h0000_7c24;
        resolve_branch(g_pc, taken, 32'h0000_7e00);
        after = {pattern[history_bits-2:0], 1'b1};
        // g2_pc xor the new history lands on the entry g_pc just trained.
        g2_pc = g_pc ^ (rv32i_word'(pattern ^ after) << addr_start);
        lookup(g2_pc);
        check_hist("shifted history", fetch_history, after);
        check_dir("hashed global_dir", global_dir, taken);
        report_test("global_history");
    endtask

    task automatic test_tournament();
        rv32i_word pc;
        rv32i_word tgt;
        int        i;
        int        pass;
        pc  = 32'h0000_9a40;
        tgt = 32'h0000_a000;
        for (i = 0; i < 16; i++) begin
            resolve_branch(pc, (i % 2 == 0) ? taken : nottaken, tgt);
        end
        for (pass = 0; pass < 2; pass++) begin
            lookup(pc);
            check_hist("alternating history", fetch_history, 8'haa);
            check_dir("alternating local_dir", local_dir, nottaken);
            check_dir("alternating global_dir", global_dir, taken);
            check_bit("global choice predict_taken", predict_taken, 1'b1);
            check_word("global choice predicted_pc", predicted_pc, tgt);
            if (pass == 0) begin
                // both tables right, history returns to 0xaa.
                issue_resolve(pc, taken, tgt, taken, taken, 8'h0f);
                issue_resolve(pc, nottaken, tgt, nottaken, nottaken, 8'hf0);
            end
        end
        report_test("tournament");
    endtask

    task automatic test_random_stream();
        rv32i_word   pcs [8];
        predictmux_t outcome;
        int          i;
        for (i = 0; i < 8; i++) begin
            pcs[i] = 32'h0000_c000 + (i % 4) * 32'h0000_0104 + (i / 4) * 32'h0001_0000;
        end
        for (i = 0; i < random_iters; i++) begin
            outcome = ($urandom % 2 == 1) ? taken : nottaken;
            resolve_branch(pcs[$urandom % 8], outcome, $urandom & 32'hffff_fffc);
            if ($urandom % 4 == 0) begin
                lookup(pcs[$urandom % 8]);
            end
        end
        report_test("random_stream");
    endtask

    initial begin
        seed_val            = $urandom(32'he69a400a);
        rst                 = 1'b1;
        fetch_pc            = '0;
        resolve_en          = 1'b0;
        resolved_pc         = '0;
        resolved_taken      = nottaken;
        resolved_target     = '0;
        resolved_local_dir  = nottaken;
        resolved_global_dir = nottaken;
        resolved_history    = '0;
        checks              = 0;
        errors              = 0;
        mark_checks         = 0;
        mark_errors         = 0;
        model_reset();
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        test_reset_state();
        test_btb_fill();
        test_local_hysteresis();
        test_global_history();
        test_tournament();
        test_random_stream();

        $display("summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// File: build.f
bp_pkg.sv
local_prediction_table.sv
gshare_prediction_table.sv
branch_target_buffer.sv
tournament_selector.sv
branch_predictor.sv
tb_branch_predictor.sv
